// File: compile.f
+incdir+source
source/axi_pkg.sv
source/regbank_pkg.sv
source/meta_fifo.sv
source/axi_to_axi_lite.sv
source/axil_reg_bank.sv
source/axi_reg_subsystem.sv
test/axi_reg_subsystem_chk.sv
test/tb_axi_reg_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f \
	--top-module tb_axi_reg_subsystem \
	-o sim_tb

output=$(./obj_dir/sim_tb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi

echo "simulation did not pass"
exit 1

// File: source/axi_pkg.sv
`default_nettype none

`include "axil_settings.svh"

package axi_pkg;

	typedef logic [`AXI_ID_WIDTH-1:0] id_t;
	typedef logic [`AXI_USER_WIDTH-1:0] user_t;
	typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
	typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t; // one bit per data byte.

	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// id sits in the upper bits, user in the lower bits.
	typedef logic [`AXI_ID_WIDTH+`AXI_USER_WIDTH-1:0] meta_t;

endpackage

`default_nettype wire

// File: source/axi_reg_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module axi_reg_subsystem (
	input  wire logic            clk_i,
	input  wire logic            rst_n_i,
	input  wire axi_pkg::addr_t  aw_addr_i,
	input  wire axi_pkg::id_t    aw_id_i,
	input  wire axi_pkg::user_t  aw_user_i,
	input  wire logic            aw_valid_i,
	output logic                 aw_ready_o,
	input  wire axi_pkg::data_t  w_data_i,
	input  wire axi_pkg::strb_t  w_strb_i,
	input  wire logic            w_valid_i,
	output logic                 w_ready_o,
	output axi_pkg::id_t         b_id_o,
	output axi_pkg::user_t       b_user_o,
	output axi_pkg::resp_t       b_resp_o,
	output logic                 b_valid_o,
	input  wire logic            b_ready_i,
	input  wire axi_pkg::addr_t  ar_addr_i,
	input  wire axi_pkg::id_t    ar_id_i,
	input  wire axi_pkg::user_t  ar_user_i,
	input  wire logic            ar_valid_i,
	output logic                 ar_ready_o,
	output axi_pkg::data_t       r_data_o,
	output axi_pkg::id_t         r_id_o,
	output axi_pkg::user_t       r_user_o,
	output axi_pkg::resp_t       r_resp_o,
	output logic                 r_last_o,
	output logic                 r_valid_o,
	input  wire logic            r_ready_i
);

	axi_pkg::addr_t lite_aw_addr;
	axi_pkg::addr_t lite_ar_addr;
	axi_pkg::data_t lite_w_data;
	axi_pkg::data_t lite_r_data;
	axi_pkg::strb_t lite_w_strb;
	axi_pkg::resp_t lite_b_resp;
	axi_pkg::resp_t lite_r_resp;
	logic lite_aw_valid;
	logic lite_aw_ready;
	logic lite_w_valid;
	logic lite_w_ready;
	logic lite_b_valid;
	logic lite_b_ready;
	logic lite_ar_valid;
	logic lite_ar_ready;
	logic lite_r_valid;
	logic lite_r_ready;

	axi_to_axi_lite i_conv (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.aw_addr_i(aw_addr_i),
		.aw_id_i(aw_id_i),
		.aw_user_i(aw_user_i),
		.aw_valid_i(aw_valid_i),
		.aw_ready_o(aw_ready_o),
		.w_data_i(w_data_i),
		.w_strb_i(w_strb_i),
		.w_valid_i(w_valid_i),
		.w_ready_o(w_ready_o),
		.b_id_o(b_id_o),
		.b_user_o(b_user_o),
		.b_resp_o(b_resp_o),
		.b_valid_o(b_valid_o),
		.b_ready_i(b_ready_i),
		.ar_addr_i(ar_addr_i),
		.ar_id_i(ar_id_i),
		.ar_user_i(ar_user_i),
		.ar_valid_i(ar_valid_i),
		.ar_ready_o(ar_ready_o),
		.r_data_o(r_data_o),
		.r_id_o(r_id_o),
		.r_user_o(r_user_o),
		.r_resp_o(r_resp_o),
		.r_last_o(r_last_o),
		.r_valid_o(r_valid_o),
		.r_ready_i(r_ready_i),
		.lite_aw_addr_o(lite_aw_addr),
		.lite_aw_valid_o(lite_aw_valid),
		.lite_aw_ready_i(lite_aw_ready),
		.lite_w_data_o(lite_w_data),
		.lite_w_strb_o(lite_w_strb),
		.lite_w_valid_o(lite_w_valid),
		.lite_w_ready_i(lite_w_ready),
		.lite_b_resp_i(lite_b_resp),
		.lite_b_valid_i(lite_b_valid),
		.lite_b_ready_o(lite_b_ready),
		.lite_ar_addr_o(lite_ar_addr),
		.lite_ar_valid_o(lite_ar_valid),
		.lite_ar_ready_i(lite_ar_ready),
		.lite_r_data_i(lite_r_data),
		.lite_r_resp_i(lite_r_resp),
		.lite_r_valid_i(lite_r_valid),
		.lite_r_ready_o(lite_r_ready)
	);

	axil_reg_bank i_regs (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.aw_addr_i(lite_aw_addr),
		.aw_valid_i(lite_aw_valid),
		.aw_ready_o(lite_aw_ready),
		.w_data_i(lite_w_data),
		.w_strb_i(lite_w_strb),
		.w_valid_i(lite_w_valid),
		.w_ready_o(lite_w_ready),
		.b_resp_o(lite_b_resp),
		.b_valid_o(lite_b_valid),
		.b_ready_i(lite_b_ready),
		.ar_addr_i(lite_ar_addr),
		.ar_valid_i(lite_ar_valid),
		.ar_ready_o(lite_ar_ready),
		.r_data_o(lite_r_data),
		.r_resp_o(lite_r_resp),
		.r_valid_o(lite_r_valid),
		.r_ready_i(lite_r_ready)
	);

endmodule

`default_nettype wire

// File: source/axi_to_axi_lite.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_settings.svh"

module axi_to_axi_lite #(
	parameter int NUM_PENDING_RD = `NUM_PENDING,
	parameter int NUM_PENDING_WR = `NUM_PENDING
) (
	input  wire logic            clk_i,
	input  wire logic            rst_n_i,
	input  wire axi_pkg::addr_t  aw_addr_i,
	input  wire axi_pkg::id_t    aw_id_i,
	input  wire axi_pkg::user_t  aw_user_i,
	input  wire logic            aw_valid_i,
	output logic                 aw_ready_o,
	input  wire axi_pkg::data_t  w_data_i,
	input  wire axi_pkg::strb_t  w_strb_i,
	input  wire logic            w_valid_i,
	output logic                 w_ready_o,
	output axi_pkg::id_t         b_id_o,
	output axi_pkg::user_t       b_user_o,
	output axi_pkg::resp_t       b_resp_o,
	output logic                 b_valid_o,
	input  wire logic            b_ready_i,
	input  wire axi_pkg::addr_t  ar_addr_i,
	input  wire axi_pkg::id_t    ar_id_i,
	input  wire axi_pkg::user_t  ar_user_i,
	input  wire logic            ar_valid_i,
	output logic                 ar_ready_o,
	output axi_pkg::data_t       r_data_o,
	output axi_pkg::id_t         r_id_o,
	output axi_pkg::user_t       r_user_o,
	output axi_pkg::resp_t       r_resp_o,
	output logic                 r_last_o,
	output logic                 r_valid_o,
	input  wire logic            r_ready_i,
	output axi_pkg::addr_t       lite_aw_addr_o,
	output logic                 lite_aw_valid_o,
	input  wire logic            lite_aw_ready_i,
	output axi_pkg::data_t       lite_w_data_o,
	output axi_pkg::strb_t       lite_w_strb_o,
	output logic                 lite_w_valid_o,
	input  wire logic            lite_w_ready_i,
	input  wire axi_pkg::resp_t  lite_b_resp_i,
	input  wire logic            lite_b_valid_i,
	output logic                 lite_b_ready_o,
	output axi_pkg::addr_t       lite_ar_addr_o,
	output logic                 lite_ar_valid_o,
	input  wire logic            lite_ar_ready_i,
	input  wire axi_pkg::data_t  lite_r_data_i,
	input  wire axi_pkg::resp_t  lite_r_resp_i,
	input  wire logic            lite_r_valid_i,
	output logic                 lite_r_ready_o
);

	localparam int DEPTH_FIFO_RD = 2 ** $clog2(NUM_PENDING_RD);
	localparam int DEPTH_FIFO_WR = 2 ** $clog2(NUM_PENDING_WR);

	axi_pkg::meta_t meta_rd;
	axi_pkg::meta_t meta_wr;
	logic rd_full;
	logic wr_full;
	logic rd_empty;
	logic wr_empty;

	meta_fifo #(
		.DEPTH(DEPTH_FIFO_RD)
	) i_fifo_rd (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.push_i(ar_valid_i && ar_ready_o),
		.data_i({ar_id_i, ar_user_i}),
		.pop_i(r_valid_o && r_ready_i),
		.data_o(meta_rd),
		.full_o(rd_full),
		.empty_o(rd_empty)
	);

	meta_fifo #(
		.DEPTH(DEPTH_FIFO_WR)
	) i_fifo_wr (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.push_i(aw_valid_i && aw_ready_o),
		.data_i({aw_id_i, aw_user_i}),
		.pop_i(b_valid_o && b_ready_i),
		.data_o(meta_wr),
		.full_o(wr_full),
		.empty_o(wr_empty)
	);

	// a full FIFO hides the request from the bank, so no address slips through unrecorded.
	assign lite_aw_valid_o = aw_valid_i && !wr_full;
	assign lite_ar_valid_o = ar_valid_i && !rd_full;
	assign aw_ready_o = lite_aw_ready_i && !wr_full;
	assign ar_ready_o = lite_ar_ready_i && !rd_full;
	assign lite_aw_addr_o = aw_addr_i;
	assign lite_ar_addr_o = ar_addr_i;

	assign lite_w_data_o = w_data_i;
	assign lite_w_strb_o = w_strb_i;
	assign lite_w_valid_o = w_valid_i;
	assign w_ready_o = lite_w_ready_i;

	assign b_valid_o = lite_b_valid_i && !wr_empty; // the bank only answers what was recorded.
	assign b_resp_o = lite_b_resp_i;
	assign b_id_o = meta_wr[`AXI_USER_WIDTH +: `AXI_ID_WIDTH];
	assign b_user_o = meta_wr[`AXI_USER_WIDTH-1:0];
	assign lite_b_ready_o = b_ready_i;

	assign r_valid_o = lite_r_valid_i && !rd_empty;
	assign r_data_o = lite_r_data_i;
	assign r_resp_o = lite_r_resp_i;
	assign r_id_o = meta_rd[`AXI_USER_WIDTH +: `AXI_ID_WIDTH];
	assign r_user_o = meta_rd[`AXI_USER_WIDTH-1:0];
	assign r_last_o = 1'b1; // every transaction is a single beat.
	assign lite_r_ready_o = r_ready_i;

endmodule

`default_nettype wire

// File: source/axil_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_settings.svh"

module axil_reg_bank (
	input  wire logic            clk_i,
	input  wire logic            rst_n_i,
	input  wire axi_pkg::addr_t  aw_addr_i,
	input  wire logic            aw_valid_i,
	output logic                 aw_ready_o,
	input  wire axi_pkg::data_t  w_data_i,
	input  wire axi_pkg::strb_t  w_strb_i,
	input  wire logic            w_valid_i,
	output logic                 w_ready_o,
	output axi_pkg::resp_t       b_resp_o,
	output logic                 b_valid_o,
	input  wire logic            b_ready_i,
	input  wire axi_pkg::addr_t  ar_addr_i,
	input  wire logic            ar_valid_i,
	output logic                 ar_ready_o,
	output axi_pkg::data_t       r_data_o,
	output axi_pkg::resp_t       r_resp_o,
	output logic                 r_valid_o,
	input  wire logic            r_ready_i
);

	localparam int IDX_LSB = 2;
	localparam int IDX_MSB = IDX_LSB + $bits(regbank_pkg::reg_idx_t) - 1;
	localparam regbank_pkg::reg_idx_t ID_IDX = regbank_pkg::reg_idx_t'(`REG_COUNT - 1);

	axi_pkg::data_t regs_q [0:`REG_COUNT-2];

	regbank_pkg::wr_state_t wr_state_q;
	regbank_pkg::rd_state_t rd_state_q;
	axi_pkg::addr_t aw_addr_q;
	axi_pkg::data_t w_data_q;
	axi_pkg::strb_t w_strb_q;
	logic aw_held_q;
	logic w_held_q;
	logic aw_hs;
	logic w_hs;
	logic ar_hs;
	logic wr_go;
	axi_pkg::addr_t wr_addr;
	axi_pkg::data_t wr_data;
	axi_pkg::strb_t wr_strb;
	regbank_pkg::reg_idx_t wr_idx;
	regbank_pkg::reg_idx_t rd_idx;
	logic wr_err;
	logic rd_err;
	axi_pkg::data_t rd_data;

	assign aw_ready_o = (wr_state_q == regbank_pkg::WR_IDLE) && !aw_held_q;
	assign w_ready_o = (wr_state_q == regbank_pkg::WR_IDLE) && !w_held_q;
	assign b_valid_o = (wr_state_q == regbank_pkg::WR_RESP);
	assign aw_hs = aw_valid_i && aw_ready_o;
	assign w_hs = w_valid_i && w_ready_o;

	// the write completes on the edge where the later of address and data arrives.
	assign wr_go = (aw_held_q || aw_hs) && (w_held_q || w_hs);
	assign wr_addr = aw_held_q ? aw_addr_q : aw_addr_i;
	assign wr_data = w_held_q ? w_data_q : w_data_i;
	assign wr_strb = w_held_q ? w_strb_q : w_strb_i;
	assign wr_idx = wr_addr[IDX_MSB:IDX_LSB];
	assign wr_err = (wr_addr[`AXI_ADDR_WIDTH-1:IDX_MSB+1] != '0) || (wr_idx == ID_IDX);

	always_ff @(posedge clk_i) begin
		if (aw_hs) begin
			aw_addr_q <= aw_addr_i;
		end
		if (w_hs) begin
			w_data_q <= w_data_i;
			w_strb_q <= w_strb_i;
		end
		if (wr_go) begin
			b_resp_o <= wr_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_state_q <= regbank_pkg::WR_IDLE;
			aw_held_q <= 1'b0;
			w_held_q <= 1'b0;
		end else begin
			case (wr_state_q)
				regbank_pkg::WR_IDLE: begin
					if (wr_go) begin
						wr_state_q <= regbank_pkg::WR_RESP;
						aw_held_q <= 1'b0;
						w_held_q <= 1'b0;
					end else begin
						aw_held_q <= aw_held_q || aw_hs;
						w_held_q <= w_held_q || w_hs;
					end
				end
				regbank_pkg::WR_RESP: begin
					if (b_ready_i) begin
						wr_state_q <= regbank_pkg::WR_IDLE;
					end
				end
				default: wr_state_q <= regbank_pkg::WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `REG_COUNT - 1; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_go && !wr_err) begin
			for (int b = 0; b < $bits(axi_pkg::strb_t); b++) begin
				if (wr_strb[b]) begin
					regs_q[wr_idx][8*b +: 8] <= wr_data[8*b +: 8]; // byte lanes merge independently.
				end
			end
		end
	end

	assign ar_ready_o = (rd_state_q == regbank_pkg::RD_IDLE);
	assign r_valid_o = (rd_state_q == regbank_pkg::RD_RESP);
	assign ar_hs = ar_valid_i && ar_ready_o;
	assign rd_idx = ar_addr_i[IDX_MSB:IDX_LSB];
	assign rd_err = (ar_addr_i[`AXI_ADDR_WIDTH-1:IDX_MSB+1] != '0);

	always_comb begin
		if (rd_err) begin
			rd_data = '0;
		end else if (rd_idx == ID_IDX) begin
			rd_data = `REG_ID_VALUE;
		end else begin
			rd_data = regs_q[rd_idx];
		end
	end

	always_ff @(posedge clk_i) begin
		if (ar_hs) begin
			r_data_o <= rd_data;
			r_resp_o <= rd_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_state_q <= regbank_pkg::RD_IDLE;
		end else begin
			case (rd_state_q)
				regbank_pkg::RD_IDLE: if (ar_hs) rd_state_q <= regbank_pkg::RD_RESP;
				regbank_pkg::RD_RESP: if (r_ready_i) rd_state_q <= regbank_pkg::RD_IDLE;
				default: rd_state_q <= regbank_pkg::RD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/axil_settings.svh
`ifndef AXIL_SETTINGS_SVH
`define AXIL_SETTINGS_SVH

// AXI field widths shared by the converter and the register bank.
`define AXI_ID_WIDTH 4
`define AXI_USER_WIDTH 2
`define AXI_ADDR_WIDTH 8
`define AXI_DATA_WIDTH 32

// register bank size, the last one is the read-only ID register.
`define REG_COUNT 8

// default number of outstanding transactions per direction.
`define NUM_PENDING 2

`define REG_ID_VALUE 32'hA5C0_0107

`endif

// File: source/meta_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module meta_fifo #(
	parameter int DEPTH = 2
) (
	input  wire logic            clk_i,
	input  wire logic            rst_n_i,
	input  wire logic            push_i,
	input  wire axi_pkg::meta_t  data_i,
	input  wire logic            pop_i,
	output axi_pkg::meta_t       data_o,
	output logic                 full_o,
	output logic                 empty_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	axi_pkg::meta_t mem [0:DEPTH-1];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic do_push;
	logic do_pop;

	assign full_o = (count_q == CNT_W'(DEPTH));
	assign empty_o = (count_q == '0);
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	assign data_o = mem[rd_ptr_q]; // head is visible without a register stage.

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			mem[wr_ptr_q] <= data_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			if (do_push && !do_pop) begin
				count_q <= count_q + 1'b1;
			end else if (do_pop && !do_push) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/regbank_pkg.sv
`default_nettype none

`include "axil_settings.svh"

package regbank_pkg;

	typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} wr_state_t;

	typedef enum logic {
		RD_IDLE,
		RD_RESP
	} rd_state_t;

endpackage

`default_nettype wire

// File: test/axi_reg_subsystem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module axi_reg_subsystem_chk #(
	parameter int WR_DEPTH = 2,
	parameter int RD_DEPTH = 2
) (
	input  wire logic            clk_i,
	input  wire logic            rst_n_i,
	input  wire logic            aw_valid_i,
	input  wire logic            aw_ready_i,
	input  wire logic            ar_valid_i,
	input  wire logic            ar_ready_i,
	input  wire logic            b_valid_i,
	input  wire logic            b_ready_i,
	input  wire logic            r_valid_i,
	input  wire logic            r_ready_i,
	input  wire logic            wr_empty_i,
	input  wire logic            rd_empty_i,
	input  wire logic            lite_b_valid_i,
	input  wire logic            lite_r_valid_i,
	input  wire axi_pkg::addr_t  lite_aw_addr_i,
	input  wire logic            lite_aw_valid_i,
	input  wire logic            lite_aw_ready_i,
	input  wire axi_pkg::addr_t  lite_ar_addr_i,
	input  wire logic            lite_ar_valid_i,
	input  wire logic            lite_ar_ready_i
);

	int wr_pending_q;
	int rd_pending_q;

	// outstanding requests counted from the AXI handshakes alone.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_pending_q <= 0;
			rd_pending_q <= 0;
		end else begin
			wr_pending_q <= wr_pending_q + int'(aw_valid_i && aw_ready_i)
				- int'(b_valid_i && b_ready_i);
			rd_pending_q <= rd_pending_q + int'(ar_valid_i && ar_ready_i)
				- int'(r_valid_i && r_ready_i);
		end
	end

	aw_blocked_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wr_pending_q >= WR_DEPTH |-> !aw_ready_i)
		else $error("aw_ready high while the write ID FIFO is full");

	ar_blocked_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rd_pending_q >= RD_DEPTH |-> !ar_ready_i)
		else $error("ar_ready high while the read ID FIFO is full");

	b_needs_entry: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		lite_b_valid_i |-> !wr_empty_i)
		else $error("b_valid with no write ID recorded");

	r_needs_entry: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		lite_r_valid_i |-> !rd_empty_i)
		else $error("r_valid with no read ID recorded");

	// a stalled lite request keeps its valid and address until the bank takes it.
	lite_aw_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		lite_aw_valid_i && !lite_aw_ready_i |=> lite_aw_valid_i && $stable(lite_aw_addr_i))
		else $error("lite aw request dropped before its transfer");

	lite_ar_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		lite_ar_valid_i && !lite_ar_ready_i |=> lite_ar_valid_i && $stable(lite_ar_addr_i))
		else $error("lite ar request dropped before its transfer");

endmodule

bind axi_to_axi_lite axi_reg_subsystem_chk #(
	.WR_DEPTH(DEPTH_FIFO_WR),
	.RD_DEPTH(DEPTH_FIFO_RD)
) i_chk (
	.clk_i(clk_i),
	.rst_n_i(rst_n_i),
	.aw_valid_i(aw_valid_i),
	.aw_ready_i(aw_ready_o),
	.ar_valid_i(ar_valid_i),
	.ar_ready_i(ar_ready_o),
	.b_valid_i(b_valid_o),
	.b_ready_i(b_ready_i),
	.r_valid_i(r_valid_o),
	.r_ready_i(r_ready_i),
	.wr_empty_i(wr_empty),
	.rd_empty_i(rd_empty),
	.lite_b_valid_i(lite_b_valid_i),
	.lite_r_valid_i(lite_r_valid_i),
	.lite_aw_addr_i(lite_aw_addr_o),
	.lite_aw_valid_i(lite_aw_valid_o),
	.lite_aw_ready_i(lite_aw_ready_i),
	.lite_ar_addr_i(lite_ar_addr_o),
	.lite_ar_valid_i(lite_ar_valid_o),
	.lite_ar_ready_i(lite_ar_ready_i)
);

`default_nettype wire

// File: test/axi_stimulus.txt
# op id user addr data strb exp_data exp_resp, all fields but op in hex
# op W sends aw and w together, A sends aw first, D sends w first, R reads
W 1 0 00 12345678 f 0 0
R 2 1 00 0 0 12345678 0
W 3 2 04 ffffffff f 0 0
W 4 3 04 00aa0055 5 0 0
R 5 0 04 0 0 ffaaff55 0
W 6 1 08 11223344 f 0 0
W 7 2 08 aabbccdd a 0 0
R 8 3 08 0 0 aa22cc44 0
R 9 0 1c 0 0 a5c00107 0
W a 1 1c deadbeef f 0 2
R b 2 1c 0 0 a5c00107 0
W c 3 20 cafef00d f 0 2
R d 0 24 0 0 0 2
R e 1 0c 0 0 0 0
A 1 2 0c 0badc0de f 0 0
D 2 3 10 13579bdf f 0 0
R 3 0 0c 0 0 0badc0de 0
R 4 1 10 0 0 13579bdf 0
W 5 0 14 01010101 f 0 0
W 6 1 18 02020202 f 0 0
W 7 2 14 f0f0f0f0 c 0 0
R 8 3 14 0 0 f0f00101 0
R 9 0 18 0 0 02020202 0
W a 1 18 00000000 1 0 0
R b 2 18 0 0 02020200 0
R c 3 04 0 0 ffaaff55 0
R d 0 00 0 0 12345678 0
W e 1 00 00000000 0 0 0
R f 2 00 0 0 12345678 0

// File: test/tb_axi_reg_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_reg_subsystem;

	localparam int WAIT_LIMIT = 200;

	typedef struct packed {
		int num;
		axi_pkg::id_t id;
		axi_pkg::user_t user;
		axi_pkg::data_t data;
		axi_pkg::resp_t resp;
	} expect_t;

	logic clk_i;
	logic rst_n_i;
	axi_pkg::addr_t aw_addr_i;
	axi_pkg::id_t aw_id_i;
	axi_pkg::user_t aw_user_i;
	logic aw_valid_i;
	logic aw_ready_o;
	axi_pkg::data_t w_data_i;
	axi_pkg::strb_t w_strb_i;
	logic w_valid_i;
	logic w_ready_o;
	axi_pkg::id_t b_id_o;
	axi_pkg::user_t b_user_o;
	axi_pkg::resp_t b_resp_o;
	logic b_valid_o;
	logic b_ready_i;
	axi_pkg::addr_t ar_addr_i;
	axi_pkg::id_t ar_id_i;
	axi_pkg::user_t ar_user_i;
	logic ar_valid_i;
	logic ar_ready_o;
	axi_pkg::data_t r_data_o;
	axi_pkg::id_t r_id_o;
	axi_pkg::user_t r_user_o;
	axi_pkg::resp_t r_resp_o;
	logic r_last_o;
	logic r_valid_o;
	logic r_ready_i;

	expect_t b_queue[$];
	expect_t r_queue[$];
	int tests_run;
	int tests_failed;
	int errors;
	int issued;
	bit timed_out;

	axi_reg_subsystem DUT (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.aw_addr_i(aw_addr_i),
		.aw_id_i(aw_id_i),
		.aw_user_i(aw_user_i),
		.aw_valid_i(aw_valid_i),
		.aw_ready_o(aw_ready_o),
		.w_data_i(w_data_i),
		.w_strb_i(w_strb_i),
		.w_valid_i(w_valid_i),
		.w_ready_o(w_ready_o),
		.b_id_o(b_id_o),
		.b_user_o(b_user_o),
		.b_resp_o(b_resp_o),
		.b_valid_o(b_valid_o),
		.b_ready_i(b_ready_i),
		.ar_addr_i(ar_addr_i),
		.ar_id_i(ar_id_i),
		.ar_user_i(ar_user_i),
		.ar_valid_i(ar_valid_i),
		.ar_ready_o(ar_ready_o),
		.r_data_o(r_data_o),
		.r_id_o(r_id_o),
		.r_user_o(r_user_o),
		.r_resp_o(r_resp_o),
		.r_last_o(r_last_o),
		.r_valid_o(r_valid_o),
		.r_ready_i(r_ready_i)
	);

	always #10 clk_i = ~clk_i;

	task automatic check_data(input string what, input axi_pkg::data_t got,
			input axi_pkg::data_t exp, inout bit ok);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			ok = 1'b0;
		end
	endtask

	task automatic check_resp(input string what, input axi_pkg::resp_t got,
			input axi_pkg::resp_t exp, inout bit ok);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			ok = 1'b0;
		end
	endtask

	task automatic check_id(input string what, input axi_pkg::id_t got,
			input axi_pkg::id_t exp, inout bit ok);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			ok = 1'b0;
		end
	endtask

	task automatic check_user(input string what, input axi_pkg::user_t got,
			input axi_pkg::user_t exp, inout bit ok);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			ok = 1'b0;
		end
	endtask

	task automatic check_last(input logic got, inout bit ok);
		if (got !== 1'b1) begin
			$display("MISMATCH at %0t ns: r_last is %b, expected 1", $time, got);
			ok = 1'b0;
		end
	endtask

	task automatic finish_test(input string kind, input expect_t e, input bit ok);
		tests_run++;
		if (!ok) begin
			tests_failed++;
		end
		$display("test %0d %s id %h: %s", e.num, kind, e.id, ok ? "ok" : "failed");
	endtask

	// samples at the falling edge, where every handshake signal is settled.
	task automatic watch_b();
		int stall;
		bit ok;
		expect_t e;
		stall = 0;
		forever begin
			@(negedge clk_i);
			if (b_valid_o && b_ready_i) begin
				if (b_queue.size() == 0) begin
					$display("ERROR at %0t ns: write response with no write outstanding", $time);
					errors++;
				end else begin
					e = b_queue.pop_front();
					ok = 1'b1;
					check_id("b_id", b_id_o, e.id, ok);
					check_user("b_user", b_user_o, e.user, ok);
					check_resp("b_resp", b_resp_o, e.resp, ok);
					finish_test("write", e, ok);
				end
				stall = int'($urandom % 4);
			end
			@(posedge clk_i);
			#1;
			b_ready_i = (stall == 0);
			if (stall > 0) begin
				stall--;
			end
		end
	endtask

	task automatic watch_r();
		int stall;
		bit ok;
		expect_t e;
		stall = 0;
		forever begin
			@(negedge clk_i);
			if (r_valid_o && r_ready_i) begin
				if (r_queue.size() == 0) begin
					$display("ERROR at %0t ns: read response with no read outstanding", $time);
					errors++;
				end else begin
					e = r_queue.pop_front();
					ok = 1'b1;
					check_id("r_id", r_id_o, e.id, ok);
					check_user("r_user", r_user_o, e.user, ok);
					check_resp("r_resp", r_resp_o, e.resp, ok);
					check_data("r_data", r_data_o, e.data, ok);
					check_last(r_last_o, ok);
					finish_test("read", e, ok);
				end
				stall = int'($urandom % 4);
			end
			@(posedge clk_i);
			#1;
			r_ready_i = (stall == 0);
			if (stall > 0) begin
				stall--;
			end
		end
	endtask

	// mode A holds w back until aw is taken, mode D does the reverse.
	task automatic issue_write(input byte mode, input axi_pkg::id_t id, input axi_pkg::user_t user,
			input axi_pkg::addr_t addr, input axi_pkg::data_t data, input axi_pkg::strb_t strb);
		int cycles;
		bit aw_fire;
		bit w_fire;
		bit aw_done;
		bit w_done;
		aw_addr_i = addr;
		aw_id_i = id;
		aw_user_i = user;
		w_data_i = data;
		w_strb_i = strb;
		aw_valid_i = (mode != "D");
		w_valid_i = (mode != "A");
		cycles = 0;
		aw_done = 1'b0;
		w_done = 1'b0;
		while (!(aw_done && w_done) && !timed_out) begin
			@(negedge clk_i);
			aw_fire = aw_valid_i && aw_ready_o;
			w_fire = w_valid_i && w_ready_o;
			@(posedge clk_i);
			#1;
			cycles++;
			if (aw_fire) begin
				aw_valid_i = 1'b0;
				aw_done = 1'b1;
			end
			if (w_fire) begin
				w_valid_i = 1'b0;
				w_done = 1'b1;
			end
			if (aw_done && !w_done) begin
				w_valid_i = 1'b1;
			end
			if (w_done && !aw_done) begin
				aw_valid_i = 1'b1;
			end
			if (!(aw_done && w_done) && cycles >= WAIT_LIMIT) begin
				$display("ERROR at %0t ns: write to address %h was never accepted", $time, addr);
				errors++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic issue_read(input axi_pkg::id_t id, input axi_pkg::user_t user,
			input axi_pkg::addr_t addr);
		int cycles;
		bit done;
		ar_addr_i = addr;
		ar_id_i = id;
		ar_user_i = user;
		ar_valid_i = 1'b1;
		cycles = 0;
		done = 1'b0;
		while (!done && !timed_out) begin
			@(negedge clk_i);
			done = ar_valid_i && ar_ready_o;
			@(posedge clk_i);
			#1;
			cycles++;
			if (done) begin
				ar_valid_i = 1'b0;
			end else if (cycles >= WAIT_LIMIT) begin
				$display("ERROR at %0t ns: read of address %h was never accepted", $time, addr);
				errors++;
				timed_out = 1'b1;
			end
		end
	endtask

	initial begin
		int fd;
		int fields;
		int cycles;
		string line;
		byte op;
		logic [31:0] id_raw;
		logic [31:0] user_raw;
		logic [31:0] addr_raw;
		logic [31:0] data_raw;
		logic [31:0] strb_raw;
		logic [31:0] exp_raw;
		logic [31:0] resp_raw;
		expect_t e;
		clk_i = 1'b0;
		rst_n_i = 1'b0;
		aw_addr_i = '0;
		aw_id_i = '0;
		aw_user_i = '0;
		aw_valid_i = 1'b0;
		w_data_i = '0;
		w_strb_i = '0;
		w_valid_i = 1'b0;
		b_ready_i = 1'b0;
		ar_addr_i = '0;
		ar_id_i = '0;
		ar_user_i = '0;
		ar_valid_i = 1'b0;
		r_ready_i = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		errors = 0;
		issued = 0;
		timed_out = 1'b0;
		void'($urandom(32'h1bd5));
		repeat (2) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		fork
			watch_b();
			watch_r();
		join_none
		fd = $fopen("test/axi_stimulus.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open the stimulus file test/axi_stimulus.txt");
			errors++;
		end else begin
			while (!timed_out && $fgets(line, fd) > 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					fields = $sscanf(line, "%c %h %h %h %h %h %h %h", op, id_raw, user_raw,
						addr_raw, data_raw, strb_raw, exp_raw, resp_raw);
					if (fields != 8) begin
						$display("ERROR: stimulus line is malformed: %s", line);
						errors++;
					end else begin
						issued++;
						e.num = issued;
						e.id = axi_pkg::id_t'(id_raw);
						e.user = axi_pkg::user_t'(user_raw);
						e.data = axi_pkg::data_t'(exp_raw);
						e.resp = axi_pkg::resp_t'(resp_raw);
						if (op == "R") begin
							r_queue.push_back(e);
							issue_read(e.id, e.user, axi_pkg::addr_t'(addr_raw));
						end else begin
							b_queue.push_back(e);
							issue_write(op, e.id, e.user, axi_pkg::addr_t'(addr_raw),
								axi_pkg::data_t'(data_raw), axi_pkg::strb_t'(strb_raw));
						end
					end
				end
			end
			$fclose(fd);
		end
		cycles = 0;
		while (!timed_out && (b_queue.size() != 0 || r_queue.size() != 0)) begin
			@(posedge clk_i);
			cycles++;
			if (cycles >= WAIT_LIMIT) begin
				$display("ERROR at %0t ns: responses still outstanding at the end", $time);
				errors++;
				timed_out = 1'b1;
			end
		end
		$display("%0d tests run, %0d failed, %0d other errors", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0 && issued > 0 && tests_run == issued) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
